// ==== design/hub_pkg.sv ====
/*
 * Shared widths, port count and memory depth of the memory hub
 * Vector typedefs and the arbiter state encoding
 */

`default_nettype none

package hub_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int NUM_PORTS  = 4;   // External master ports
  localparam int ADDR_W     = 32;  // Byte address
  localparam int DATA_W     = 32;
  localparam int SEL_W      = DATA_W / 8;
  localparam int PORT_IDX_W = 2;   // Enough for NUM_PORTS
  localparam int MEM_WORDS  = 256;
  localparam int WORD_IDX_W = 8;   // log2 of MEM_WORDS

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [SEL_W-1:0]      sel_t;
  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  // Arbiter FSM
  typedef enum logic {
    ARB_IDLE = 1'b0,  // No owner, looking for a cyc
    ARB_BUSY = 1'b1   // Grant held until the owner drops cyc
  } arb_state_e;

endpackage

`default_nettype wire

// ==== design/port_arbiter.sv ====
/*
 * Round-robin arbiter over the master cyc lines
 * Grant is held for the whole bus cycle of the owner
 */

`default_nettype none

module port_arbiter (
  input  logic                             periph_clk,
  input  logic                             rst_i,
  input  logic [hub_pkg::NUM_PORTS-1:0]    cyc_i,
  output hub_pkg::port_idx_t               grant_idx_o,
  output logic                             grant_valid_o
);

  import hub_pkg::*;

  arb_state_e state_q;
  port_idx_t  grant_q;
  port_idx_t  last_q;      // Last port granted, search starts after it

  port_idx_t  pick_idx;
  logic       pick_found;
  port_idx_t  cand;

  //////////////////////////////
  // Round-robin pick
  //////////////////////////////

  // First requesting port after last_q, wrapping around once
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = last_q;
    cand       = last_q;
    for (int i = 1; i <= NUM_PORTS; i++) begin
      cand = port_idx_t'((int'(last_q) + i) % NUM_PORTS);
      if (!pick_found && cyc_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      state_q <= ARB_IDLE;
      grant_q <= '0;
      last_q  <= port_idx_t'(NUM_PORTS - 1);  // Port 0 wins first
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (pick_found) begin
            state_q <= ARB_BUSY;
            grant_q <= pick_idx;
            last_q  <= pick_idx;
          end
        end
        ARB_BUSY: begin
          // Owner gave up the bus
          if (!cyc_i[grant_q]) begin
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  assign grant_idx_o   = grant_q;
  assign grant_valid_o = (state_q == ARB_BUSY);

endmodule

`default_nettype wire

// ==== design/bus_mux.sv ====
/*
 * Request steering from the granted master port to the memory target
 * Response routing of ack, err and read data back to that port
 */

`default_nettype none

module bus_mux (
  input  hub_pkg::port_idx_t                          grant_idx_i,
  input  logic                                        grant_valid_i,
  // Master ports
  input  logic [hub_pkg::NUM_PORTS-1:0]               port_cyc_i,
  input  logic [hub_pkg::NUM_PORTS-1:0]               port_stb_i,
  input  logic [hub_pkg::NUM_PORTS-1:0]               port_we_i,
  input  hub_pkg::addr_t [hub_pkg::NUM_PORTS-1:0]     port_adr_i,
  input  hub_pkg::data_t [hub_pkg::NUM_PORTS-1:0]     port_dat_i,
  input  hub_pkg::sel_t  [hub_pkg::NUM_PORTS-1:0]     port_sel_i,
  output hub_pkg::data_t [hub_pkg::NUM_PORTS-1:0]     port_dat_o,
  output logic [hub_pkg::NUM_PORTS-1:0]               port_ack_o,
  output logic [hub_pkg::NUM_PORTS-1:0]               port_err_o,
  // Target side
  output logic                                        tgt_cyc_o,
  output logic                                        tgt_stb_o,
  output logic                                        tgt_we_o,
  output hub_pkg::addr_t                              tgt_adr_o,
  output hub_pkg::data_t                              tgt_dat_o,
  output hub_pkg::sel_t                               tgt_sel_o,
  output hub_pkg::port_idx_t                          tgt_tga_o,
  input  hub_pkg::data_t                              tgt_dat_i,
  input  logic                                        tgt_ack_i,
  input  logic                                        tgt_err_i
);

  import hub_pkg::*;

  //////////////////////////////
  // Request path
  //////////////////////////////

  always_comb begin
    tgt_cyc_o = 1'b0;
    tgt_stb_o = 1'b0;
    tgt_we_o  = 1'b0;
    tgt_adr_o = '0;
    tgt_dat_o = '0;
    tgt_sel_o = '0;
    tgt_tga_o = '0;
    if (grant_valid_i) begin
      tgt_cyc_o = port_cyc_i[grant_idx_i];
      tgt_stb_o = port_cyc_i[grant_idx_i] & port_stb_i[grant_idx_i];
      tgt_we_o  = port_we_i[grant_idx_i];
      tgt_adr_o = port_adr_i[grant_idx_i];
      tgt_dat_o = port_dat_i[grant_idx_i];
      tgt_sel_o = port_sel_i[grant_idx_i];
      tgt_tga_o = grant_idx_i;            // Tag with the owning port
    end
  end

  //////////////////////////////
  // Response path
  //////////////////////////////

  // Only the owner sees a response, the rest stay quiet
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (grant_valid_i && grant_idx_i == port_idx_t'(p)) begin
        port_ack_o[p] = tgt_ack_i;
        port_err_o[p] = tgt_err_i;
        port_dat_o[p] = tgt_dat_i;
      end else begin
        port_ack_o[p] = 1'b0;
        port_err_o[p] = 1'b0;
        port_dat_o[p] = '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/sim_mem.sv ====
/*
 * Wishbone classic word memory with byte-select writes
 * Contents read as zero until written, range error past the last word
 */

`default_nettype none

module sim_mem (
  input  logic                 periph_clk,
  input  logic                 rst_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  hub_pkg::addr_t       adr_i,
  input  hub_pkg::data_t       dat_i,
  input  hub_pkg::sel_t        sel_i,
  input  hub_pkg::port_idx_t   tga_i,
  output hub_pkg::data_t       dat_o,
  output logic                 ack_o,
  output logic                 err_o
);

  import hub_pkg::*;

  data_t     mem_q [MEM_WORDS];

  logic                  ack_q;
  logic                  err_q;
  data_t                 dat_q;

  logic [ADDR_W-3:0]     word_adr;
  word_idx_t             word_idx;
  logic                  in_range;
  logic                  access;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign word_adr = adr_i[ADDR_W-1:2];
  assign word_idx = word_idx_t'(adr_i[WORD_IDX_W+1:2]);
  assign in_range = (word_adr < MEM_WORDS);

  // Skip the cycle after a response so a held stb is not served twice
  assign access = cyc_i & stb_i & ~ack_q & ~err_q;

  //////////////////////////////
  // Storage and handshake
  //////////////////////////////

  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;                  // Unwritten words read as zero
      end
    end else begin
      ack_q <= access & in_range;
      err_q <= access & ~in_range;
      if (access && in_range && we_i) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (sel_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data, zero for writes and range errors
  always_ff @(posedge periph_clk) begin
    if (access) begin
      dat_q <= (in_range && !we_i) ? mem_q[word_idx] : '0;
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;
  assign err_o = err_q;

endmodule

`default_nettype wire

// ==== design/shared_mem_hub.sv ====
/*
 * Top level of the shared memory hub
 * Arbiter, request multiplexer and memory target
 */

`default_nettype none

module shared_mem_hub (
  input  logic                                      periph_clk,
  input  logic                                      rst_i,
  input  logic [hub_pkg::NUM_PORTS-1:0]             wb_cyc_i,
  input  logic [hub_pkg::NUM_PORTS-1:0]             wb_stb_i,
  input  logic [hub_pkg::NUM_PORTS-1:0]             wb_we_i,
  input  hub_pkg::addr_t [hub_pkg::NUM_PORTS-1:0]   wb_adr_i,
  input  hub_pkg::data_t [hub_pkg::NUM_PORTS-1:0]   wb_dat_i,
  input  hub_pkg::sel_t  [hub_pkg::NUM_PORTS-1:0]   wb_sel_i,
  output hub_pkg::data_t [hub_pkg::NUM_PORTS-1:0]   wb_dat_o,
  output logic [hub_pkg::NUM_PORTS-1:0]             wb_ack_o,
  output logic [hub_pkg::NUM_PORTS-1:0]             wb_err_o
);

  import hub_pkg::*;

  port_idx_t grant_idx;
  logic      grant_valid;

  // Muxed bus towards the memory
  logic      tgt_cyc;
  logic      tgt_stb;
  logic      tgt_we;
  addr_t     tgt_adr;
  data_t     tgt_wdat;
  sel_t      tgt_sel;
  port_idx_t tgt_tga;
  data_t     tgt_rdat;
  logic      tgt_ack;
  logic      tgt_err;

  port_arbiter i_port_arbiter (
    .periph_clk    ( periph_clk  ),
    .rst_i         ( rst_i       ),
    .cyc_i         ( wb_cyc_i    ),
    .grant_idx_o   ( grant_idx   ),
    .grant_valid_o ( grant_valid )
  );

  bus_mux i_bus_mux (
    .grant_idx_i   ( grant_idx   ),
    .grant_valid_i ( grant_valid ),
    .port_cyc_i    ( wb_cyc_i    ),
    .port_stb_i    ( wb_stb_i    ),
    .port_we_i     ( wb_we_i     ),
    .port_adr_i    ( wb_adr_i    ),
    .port_dat_i    ( wb_dat_i    ),
    .port_sel_i    ( wb_sel_i    ),
    .port_dat_o    ( wb_dat_o    ),
    .port_ack_o    ( wb_ack_o    ),
    .port_err_o    ( wb_err_o    ),
    .tgt_cyc_o     ( tgt_cyc     ),
    .tgt_stb_o     ( tgt_stb     ),
    .tgt_we_o      ( tgt_we      ),
    .tgt_adr_o     ( tgt_adr     ),
    .tgt_dat_o     ( tgt_wdat    ),
    .tgt_sel_o     ( tgt_sel     ),
    .tgt_tga_o     ( tgt_tga     ),
    .tgt_dat_i     ( tgt_rdat    ),
    .tgt_ack_i     ( tgt_ack     ),
    .tgt_err_i     ( tgt_err     )
  );

  sim_mem i_sim_mem (
    .periph_clk ( periph_clk ),
    .rst_i      ( rst_i      ),
    .cyc_i      ( tgt_cyc    ),
    .stb_i      ( tgt_stb    ),
    .we_i       ( tgt_we     ),
    .adr_i      ( tgt_adr    ),
    .dat_i      ( tgt_wdat   ),
    .sel_i      ( tgt_sel    ),
    .tga_i      ( tgt_tga    ),
    .dat_o      ( tgt_rdat   ),
    .ack_o      ( tgt_ack    ),
    .err_o      ( tgt_err    )
  );

endmodule

`default_nettype wire

// ==== test/hub_assertions.sv ====
/*
 * Handshake and fairness assertions for the shared memory hub
 */

`default_nettype none

module hub_assertions (
  input logic                              periph_clk,
  input logic                              rst_i,
  input logic [hub_pkg::NUM_PORTS-1:0]     wb_cyc_i,
  input logic [hub_pkg::NUM_PORTS-1:0]     wb_stb_i,
  input logic [hub_pkg::NUM_PORTS-1:0]     wb_ack_o,
  input logic [hub_pkg::NUM_PORTS-1:0]     wb_err_o,
  input hub_pkg::port_idx_t                grant_idx_i,
  input logic                              grant_valid_i
);

  import hub_pkg::*;

  int   fail_count = 0;            // Read by the testbench at the end
  int   wait_cnt [NUM_PORTS];      // Foreign ownerships seen while waiting
  logic [NUM_PORTS-1:0] own_end;

  // Owner drops cyc, arbiter goes idle at this edge
  always_comb begin
    for (int q = 0; q < NUM_PORTS; q++) begin
      own_end[q] = grant_valid_i && grant_idx_i == port_idx_t'(q) && !wb_cyc_i[q];
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    always_ff @(posedge periph_clk) begin
      if (rst_i || !(wb_cyc_i[p] && wb_stb_i[p]) || wb_ack_o[p] || wb_err_o[p]) begin
        wait_cnt[p] <= 0;
      end else if (|(own_end & ~(NUM_PORTS'(1) << p))) begin
        wait_cnt[p] <= wait_cnt[p] + 1;
      end
    end

    a_excl: assert property (@(posedge periph_clk) disable iff (rst_i)
      !(wb_ack_o[p] && wb_err_o[p]))
      else begin
        fail_count++;
        $error("ack and err both high on port %0d", p);
      end

    a_stb: assert property (@(posedge periph_clk) disable iff (rst_i)
      (wb_ack_o[p] || wb_err_o[p]) |-> (wb_cyc_i[p] && wb_stb_i[p]))
      else begin
        fail_count++;
        $error("response without stb on port %0d", p);
      end

    a_ack_w: assert property (@(posedge periph_clk) disable iff (rst_i)
      wb_ack_o[p] |=> !wb_ack_o[p])
      else begin
        fail_count++;
        $error("ack wider than one cycle on port %0d", p);
      end

    a_err_w: assert property (@(posedge periph_clk) disable iff (rst_i)
      wb_err_o[p] |=> !wb_err_o[p])
      else begin
        fail_count++;
        $error("err wider than one cycle on port %0d", p);
      end

    a_fair: assert property (@(posedge periph_clk) disable iff (rst_i)
      wait_cnt[p] <= NUM_PORTS - 1)
      else begin
        fail_count++;
        $error("port %0d starved by round-robin", p);
      end
  end

  a_rst: assert property (@(posedge periph_clk)
    $fell(rst_i) |-> (wb_ack_o == '0 && wb_err_o == '0))
    else begin
      fail_count++;
      $error("response high right after reset");
    end

endmodule

bind shared_mem_hub hub_assertions i_hub_assertions (
  .periph_clk    ( periph_clk  ),
  .rst_i         ( rst_i       ),
  .wb_cyc_i      ( wb_cyc_i    ),
  .wb_stb_i      ( wb_stb_i    ),
  .wb_ack_o      ( wb_ack_o    ),
  .wb_err_o      ( wb_err_o    ),
  .grant_idx_i   ( grant_idx   ),
  .grant_valid_i ( grant_valid )
);

`default_nettype wire

// ==== test/tb_shared_mem_hub.sv ====
/*
 * Testbench for the shared memory hub
 * Directed and random per-port traffic against a reference memory
 */

`default_nettype none

module tb_shared_mem_hub;

  import hub_pkg::*;

  localparam int NUM_RAND    = 40;                      // Random transfers per port
  localparam int XFERS_TOTAL = NUM_PORTS * NUM_RAND + 8;
  localparam int LIMIT_CYC   = XFERS_TOTAL * NUM_PORTS * 4 + 200;

  logic                          periph_clk;
  logic                          rst_i;
  logic [NUM_PORTS-1:0]          wb_cyc_i;
  logic [NUM_PORTS-1:0]          wb_stb_i;
  logic [NUM_PORTS-1:0]          wb_we_i;
  addr_t [NUM_PORTS-1:0]         wb_adr_i;
  data_t [NUM_PORTS-1:0]         wb_dat_i;
  sel_t  [NUM_PORTS-1:0]         wb_sel_i;
  data_t [NUM_PORTS-1:0]         wb_dat_o;
  logic [NUM_PORTS-1:0]          wb_ack_o;
  logic [NUM_PORTS-1:0]          wb_err_o;

  data_t ref_mem [MEM_WORDS];     // Reference contents
  int    seed       = 32'h4b29d12a;
  int    mismatches = 0;
  int    lat;

  shared_mem_hub i_dut (
    .periph_clk ( periph_clk ),
    .rst_i      ( rst_i      ),
    .wb_cyc_i   ( wb_cyc_i   ),
    .wb_stb_i   ( wb_stb_i   ),
    .wb_we_i    ( wb_we_i    ),
    .wb_adr_i   ( wb_adr_i   ),
    .wb_dat_i   ( wb_dat_i   ),
    .wb_sel_i   ( wb_sel_i   ),
    .wb_dat_o   ( wb_dat_o   ),
    .wb_ack_o   ( wb_ack_o   ),
    .wb_err_o   ( wb_err_o   )
  );

  initial begin
    periph_clk = 1'b0;
    forever #4 periph_clk = ~periph_clk;
  end

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  // One classic transfer, request held until ack or err was sampled
  task automatic bus_xfer(input int p, input logic we, input addr_t adr, input data_t wdat,
                          input sel_t sel, output data_t rdat, output logic got_ack,
                          output logic got_err, output int cycles);
    cycles = 0;
    wb_cyc_i[p] = 1'b1;
    wb_stb_i[p] = 1'b1;
    wb_we_i[p]  = we;
    wb_adr_i[p] = adr;
    wb_dat_i[p] = wdat;
    wb_sel_i[p] = sel;
    do begin
      @(negedge periph_clk);
      cycles++;
    end while (!wb_ack_o[p] && !wb_err_o[p]);
    got_ack = wb_ack_o[p];
    got_err = wb_err_o[p];
    rdat    = wb_dat_o[p];
    @(negedge periph_clk);                // Master samples at the next rising edge
    wb_cyc_i[p] = 1'b0;
    wb_stb_i[p] = 1'b0;
  endtask

  // Transfer plus comparison with the reference memory
  task automatic checked_xfer(input int p, input logic we, input addr_t adr,
                              input data_t wdat, input sel_t sel, output int cycles);
    data_t             rdat;
    data_t             exp;
    logic              got_ack;
    logic              got_err;
    logic              exp_err;
    logic [ADDR_W-3:0] word;
    bus_xfer(p, we, adr, wdat, sel, rdat, got_ack, got_err, cycles);
    word    = adr[ADDR_W-1:2];
    exp_err = (word >= ADDR_W'(MEM_WORDS));
    if (got_err !== exp_err || got_ack !== !exp_err) begin
      $display("Mismatch at %0t: port %0d word %0d ack=%0b err=%0b, expected err=%0b",
               $time, p, word, got_ack, got_err, exp_err);
      mismatches++;
    end
    exp = (exp_err || we) ? '0 : ref_mem[word[WORD_IDX_W-1:0]];
    if ((!we || exp_err) && rdat !== exp) begin
      $display("Mismatch at %0t: port %0d word %0d read %h, expected %h",
               $time, p, word, rdat, exp);
      mismatches++;
    end
    if (we && !exp_err) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (sel[b]) ref_mem[word[WORD_IDX_W-1:0]][8*b +: 8] = wdat[8*b +: 8];
      end
    end
  endtask

  task automatic random_traffic(input int p);
    int    cyc;
    int    word;
    int    gap;
    logic  we;
    for (int n = 0; n < NUM_RAND; n++) begin
      word = $unsigned($random(seed)) % (MEM_WORDS + 32);   // Some past the end
      we   = $random(seed);
      checked_xfer(p, we, addr_t'(word * 4), $random(seed), sel_t'($random(seed)), cyc);
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge periph_clk);
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    #(LIMIT_CYC * 8);
    $display("Timeout: transfers did not complete within %0d cycles", LIMIT_CYC);
    $display("Errors found");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    wb_cyc_i = '0;
    wb_stb_i = '0;
    wb_we_i  = '0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    for (int w = 0; w < MEM_WORDS; w++) ref_mem[w] = '0;
    rst_i = 1'b1;
    repeat (5) @(negedge periph_clk);
    rst_i = 1'b0;
    @(negedge periph_clk);

    // Fresh word reads zero, two cycles on an idle hub
    checked_xfer(0, 1'b0, addr_t'(5 * 4), '0, 4'hf, lat);
    if (lat != 2) begin
      $display("Mismatch at %0t: idle read latency %0d, expected 2", $time, lat);
      mismatches++;
    end

    // Byte merge, written by one port and read by another
    checked_xfer(1, 1'b1, addr_t'(10 * 4), 32'hA1B2C3D4, 4'b0101, lat);
    checked_xfer(3, 1'b1, addr_t'(10 * 4), 32'h11223344, 4'b1000, lat);
    checked_xfer(2, 1'b0, addr_t'(10 * 4), '0, 4'hf, lat);

    // Out of range write must not touch the aliased word
    checked_xfer(3, 1'b1, addr_t'((MEM_WORDS + 10) * 4), 32'hDEADBEEF, 4'hf, lat);
    checked_xfer(0, 1'b0, addr_t'((MEM_WORDS + 10) * 4), '0, 4'hf, lat);
    checked_xfer(1, 1'b0, addr_t'(10 * 4), '0, 4'hf, lat);

    // All ports at once
    fork
      random_traffic(0);
      random_traffic(1);
      random_traffic(2);
      random_traffic(3);
    join
    repeat (4) @(negedge periph_clk);

    $display("Data mismatches: %0d, assertion failures: %0d",
             mismatches, i_dut.i_hub_assertions.fail_count);
    if (mismatches == 0 && i_dut.i_hub_assertions.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
design/hub_pkg.sv
design/port_arbiter.sv
design/bus_mux.sv
design/sim_mem.sv
design/shared_mem_hub.sv
test/hub_assertions.sv
test/tb_shared_mem_hub.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the shared memory hub simulation with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=$BUILD_DIR/sim.log
TOP=tb_shared_mem_hub

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Cannot create $BUILD_DIR"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR/obj" \
  -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
"$BUILD_DIR/obj/V$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -qx "No errors" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
